/* include/router_settings.svh */
`ifndef ROUTER_SETTINGS_SVH
`define ROUTER_SETTINGS_SVH

// Flit payload width in bits.
`define ROUTER_FLIT_W 32

// Packet length and hold count width.
`define ROUTER_LEN_W 12

`define ROUTER_ID_W 3

// Local, North, East, West, South.
`define ROUTER_PORTS 5

// Flit id that marks a header flit.
`define ROUTER_HEAD_ID 1

`endif

/* src/routerPkg.sv */
`default_nettype none

`include "router_settings.svh"

package routerPkg;

  typedef logic [`ROUTER_FLIT_W-1:0] flitT;
  typedef logic [`ROUTER_ID_W-1:0] flitIdT;
  typedef logic [`ROUTER_LEN_W-1:0] lengthT;

  // Bit 0 is Local up to bit 4 for South.
  typedef logic [`ROUTER_PORTS-1:0] portMaskT;
  typedef logic [$clog2(`ROUTER_PORTS)-1:0] portIdxT;

  // One-hot grant state. Bit k+1 means port k holds the output.
  typedef enum logic [5:0] {
    Idle   = 6'b000001,
    GrantL = 6'b000010,
    GrantN = 6'b000100,
    GrantE = 6'b001000,
    GrantW = 6'b010000,
    GrantS = 6'b100000
  } grantStateT;

endpackage

`default_nettype wire

/* src/holdTimer.sv */
`default_nettype none

`include "router_settings.svh"

module holdTimer
  import routerPkg::*;
(
  input  wire    clk,
  input  wire    rst,
  input  wire    flitIdT flitId,
  input  wire    lengthT length,
  input  wire    lengthT lengthCap,
  input  wire    run,
  output logic   timesUp
);

  lengthT count;
  lengthT limit;
  lengthT cappedLength;

  assign cappedLength = (length < lengthCap) ? length : lengthCap;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      count <= '0;
      limit <= '0;
    end
    else
    begin
      if (flitId == flitIdT'(`ROUTER_HEAD_ID))
        limit <= cappedLength; // Header flit sets the hold length.
      if (run)
        count <= count + lengthT'(1);
      else
        count <= '0; // Any gap in forwarding restarts the count.
    end
  end

  assign timesUp = (count == limit);

  // The arbiter only runs the timer while the hold is not used up.
  assert property (@(posedge clk) disable iff (rst) run |-> count < limit);

endmodule

`default_nettype wire

/* src/portArbiter.sv */
`default_nettype none

`include "router_settings.svh"

module portArbiter
  import routerPkg::*;
(
  input  wire      clk,
  input  wire      rst,
  input  wire      portMaskT req,
  input  wire      flitIdT flitId0,
  input  wire      flitIdT flitId1,
  input  wire      flitIdT flitId2,
  input  wire      flitIdT flitId3,
  input  wire      flitIdT flitId4,
  input  wire      lengthT length0,
  input  wire      lengthT length1,
  input  wire      lengthT length2,
  input  wire      lengthT length3,
  input  wire      lengthT length4,
  input  wire      portMaskT portEnable,
  input  wire      lengthT lengthCap,
  output portMaskT forward
);

  grantStateT state;
  grantStateT nextState;
  portMaskT   effReq;
  portMaskT   timesUp;

  // First requester among span ports starting at start. Idle if none.
  function automatic grantStateT firstReq(portMaskT reqs, int start, int span);
    grantStateT pick;
    int p;
    pick = Idle;
    for (int i = span - 1; i >= 0; i--)
    begin
      p = (start + i) % `ROUTER_PORTS;
      if (reqs[p])
        pick = grantStateT'(6'b000010 << p); // Lowest offset wins.
    end
    return pick;
  endfunction

  assign effReq = req & portEnable;

  holdTimer i_holdTimerL (
    .clk       (clk),
    .rst       (rst),
    .flitId    (flitId0),
    .length    (length0),
    .lengthCap (lengthCap),
    .run       (forward[0]),
    .timesUp   (timesUp[0])
  );

  holdTimer i_holdTimerN (
    .clk       (clk),
    .rst       (rst),
    .flitId    (flitId1),
    .length    (length1),
    .lengthCap (lengthCap),
    .run       (forward[1]),
    .timesUp   (timesUp[1])
  );

  holdTimer i_holdTimerE (
    .clk       (clk),
    .rst       (rst),
    .flitId    (flitId2),
    .length    (length2),
    .lengthCap (lengthCap),
    .run       (forward[2]),
    .timesUp   (timesUp[2])
  );

  holdTimer i_holdTimerW (
    .clk       (clk),
    .rst       (rst),
    .flitId    (flitId3),
    .length    (length3),
    .lengthCap (lengthCap),
    .run       (forward[3]),
    .timesUp   (timesUp[3])
  );

  holdTimer i_holdTimerS (
    .clk       (clk),
    .rst       (rst),
    .flitId    (flitId4),
    .length    (length4),
    .lengthCap (lengthCap),
    .run       (forward[4]),
    .timesUp   (timesUp[4])
  );

  always_ff @(posedge clk)
  begin
    if (rst)
      state <= Idle;
    else
      state <= nextState;
  end

  // A finished holder passes to the next four ports in turn and then to Idle.
  always_comb
  begin
    forward = '0;
    nextState = Idle;
    case (state)
      Idle:
        nextState = firstReq(effReq, 0, `ROUTER_PORTS);
      GrantL:
        if (effReq[0] && !timesUp[0])
        begin
          forward[0] = 1'b1;
          nextState = GrantL;
        end
        else
          nextState = firstReq(effReq, 1, `ROUTER_PORTS - 1);
      GrantN:
        if (effReq[1] && !timesUp[1])
        begin
          forward[1] = 1'b1;
          nextState = GrantN;
        end
        else
          nextState = firstReq(effReq, 2, `ROUTER_PORTS - 1);
      GrantE:
        if (effReq[2] && !timesUp[2])
        begin
          forward[2] = 1'b1;
          nextState = GrantE;
        end
        else
          nextState = firstReq(effReq, 3, `ROUTER_PORTS - 1);
      GrantW:
        if (effReq[3] && !timesUp[3])
        begin
          forward[3] = 1'b1;
          nextState = GrantW;
        end
        else
          nextState = firstReq(effReq, 4, `ROUTER_PORTS - 1);
      GrantS:
        if (effReq[4] && !timesUp[4])
        begin
          forward[4] = 1'b1;
          nextState = GrantS;
        end
        else
          nextState = firstReq(effReq, 0, `ROUTER_PORTS - 1); // Wraps to Local.
      default:
        nextState = Idle;
    endcase
  end

  assert property (@(posedge clk) disable iff (rst) $onehot(state));
  assert property (@(posedge clk) disable iff (rst) $onehot0(forward));
  assert property (@(posedge clk) disable iff (rst) (forward & ~portEnable) == '0);

endmodule

`default_nettype wire

/* src/portConfig.sv */
`default_nettype none

`include "router_settings.svh"

module portConfig
  import routerPkg::*;
(
  input  wire      clk,
  input  wire      rst,
  input  wire      cfgWrite,
  input  wire      cfgAddr,
  input  wire      lengthT cfgWdata,
  output lengthT   cfgRdata,
  output portMaskT portEnable,
  output lengthT   lengthCap
);

  // Address 0 is the port mask and address 1 the length cap.
  localparam logic AddrMask = 1'b0;
  localparam logic AddrCap  = 1'b1;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      portEnable <= '1; // All ports on.
      lengthCap  <= '1; // No cap.
    end
    else if (cfgWrite)
    begin
      if (cfgAddr == AddrMask)
        portEnable <= cfgWdata[`ROUTER_PORTS-1:0];
      if (cfgAddr == AddrCap)
        lengthCap <= cfgWdata;
    end
  end

  always_comb
  begin
    if (cfgAddr == AddrCap)
      cfgRdata = lengthCap;
    else
      cfgRdata = lengthT'(portEnable); // Upper bits read as zero.
  end

endmodule

`default_nettype wire

/* src/flitCrossbar.sv */
`default_nettype none

`include "router_settings.svh"

module flitCrossbar
  import routerPkg::*;
(
  input  wire     clk,
  input  wire     rst,
  input  wire     portMaskT forward,
  input  wire     flitT flit0,
  input  wire     flitT flit1,
  input  wire     flitT flit2,
  input  wire     flitT flit3,
  input  wire     flitT flit4,
  output flitT    outFlit,
  output logic    outValid,
  output portIdxT outPort
);

  flitT    flits [`ROUTER_PORTS];
  flitT    selFlit;
  portIdxT selPort;

  assign flits[0] = flit0;
  assign flits[1] = flit1;
  assign flits[2] = flit2;
  assign flits[3] = flit3;
  assign flits[4] = flit4;

  // At most one forward bit is set.
  always_comb
  begin
    selFlit = flits[0];
    selPort = '0;
    for (int k = 0; k < `ROUTER_PORTS; k++)
    begin
      if (forward[k])
      begin
        selFlit = flits[k];
        selPort = portIdxT'(k);
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      outValid <= 1'b0;
    else
      outValid <= |forward;
  end

  always_ff @(posedge clk)
  begin
    if (|forward)
    begin
      outFlit <= selFlit; // Holds the last flit between bursts.
      outPort <= selPort;
    end
  end

endmodule

`default_nettype wire

/* src/routerSwitch.sv */
`default_nettype none

`include "router_settings.svh"

module routerSwitch
  import routerPkg::*;
(
  input  wire     clk,
  input  wire     rst,
  input  wire     flitT flit0,
  input  wire     flitT flit1,
  input  wire     flitT flit2,
  input  wire     flitT flit3,
  input  wire     flitT flit4,
  input  wire     flitIdT flitId0,
  input  wire     flitIdT flitId1,
  input  wire     flitIdT flitId2,
  input  wire     flitIdT flitId3,
  input  wire     flitIdT flitId4,
  input  wire     lengthT length0,
  input  wire     lengthT length1,
  input  wire     lengthT length2,
  input  wire     lengthT length3,
  input  wire     lengthT length4,
  input  wire     req0,
  input  wire     req1,
  input  wire     req2,
  input  wire     req3,
  input  wire     req4,
  input  wire     cfgWrite,
  input  wire     cfgAddr,
  input  wire     lengthT cfgWdata,
  output lengthT  cfgRdata,
  output flitT    outFlit,
  output logic    outValid,
  output portIdxT outPort
);

  portMaskT portEnable;
  lengthT   lengthCap;
  portMaskT forward;

  portConfig i_portConfig (
    .clk        (clk),
    .rst        (rst),
    .cfgWrite   (cfgWrite),
    .cfgAddr    (cfgAddr),
    .cfgWdata   (cfgWdata),
    .cfgRdata   (cfgRdata),
    .portEnable (portEnable),
    .lengthCap  (lengthCap)
  );

  portArbiter i_portArbiter (
    .clk        (clk),
    .rst        (rst),
    .req        ({req4, req3, req2, req1, req0}), // Local in bit 0.
    .flitId0    (flitId0),
    .flitId1    (flitId1),
    .flitId2    (flitId2),
    .flitId3    (flitId3),
    .flitId4    (flitId4),
    .length0    (length0),
    .length1    (length1),
    .length2    (length2),
    .length3    (length3),
    .length4    (length4),
    .portEnable (portEnable),
    .lengthCap  (lengthCap),
    .forward    (forward)
  );

  flitCrossbar i_flitCrossbar (
    .clk      (clk),
    .rst      (rst),
    .forward  (forward),
    .flit0    (flit0),
    .flit1    (flit1),
    .flit2    (flit2),
    .flit3    (flit3),
    .flit4    (flit4),
    .outFlit  (outFlit),
    .outValid (outValid),
    .outPort  (outPort)
  );

endmodule

`default_nettype wire

/* dv/tbRouterSwitch.sv */
`default_nettype none

`include "router_settings.svh"

module tbRouterSwitch
  import routerPkg::*;
;
  timeunit 1ns;
  timeprecision 1ps;

  logic clk = 1'b0;
  logic rst;
  logic [4:0] reqVec;
  flitT flits [5];
  flitIdT ids [5];
  lengthT lens [5];
  logic cfgWrite;
  logic cfgAddr;
  lengthT cfgWdata;
  lengthT cfgRdata;
  flitT outFlit;
  logic outValid;
  portIdxT outPort;

  int errors = 0;
  string testName = "reset";
  bit synced = 1'b0;
  bit maskOn = 1'b0;
  bit capOn = 1'b0;

  // Model of the arbiter and timers, one cycle ahead of the DUT outputs.
  int mState;
  lengthT mCount [5];
  lengthT mLimit [5];
  portMaskT mMask;
  lengthT mCap;
  bit expValid;
  flitT expFlit;
  portIdxT expPort;
  int runLen = 0;
  bit lastValid = 1'b0;
  portIdxT lastPort = '0;

  always #4 clk = ~clk;

  routerSwitch i_routerSwitch (
    .clk      (clk),
    .rst      (rst),
    .flit0    (flits[0]),
    .flit1    (flits[1]),
    .flit2    (flits[2]),
    .flit3    (flits[3]),
    .flit4    (flits[4]),
    .flitId0  (ids[0]),
    .flitId1  (ids[1]),
    .flitId2  (ids[2]),
    .flitId3  (ids[3]),
    .flitId4  (ids[4]),
    .length0  (lens[0]),
    .length1  (lens[1]),
    .length2  (lens[2]),
    .length3  (lens[3]),
    .length4  (lens[4]),
    .req0     (reqVec[0]),
    .req1     (reqVec[1]),
    .req2     (reqVec[2]),
    .req3     (reqVec[3]),
    .req4     (reqVec[4]),
    .cfgWrite (cfgWrite),
    .cfgAddr  (cfgAddr),
    .cfgWdata (cfgWdata),
    .cfgRdata (cfgRdata),
    .outFlit  (outFlit),
    .outValid (outValid),
    .outPort  (outPort)
  );

  // Grant rule: holder keeps going, else search the next ports in rotating order.
  function automatic void nextGrant(input int st, input portMaskT eff, input portMaskT tUp,
                                    output int nxt, output portMaskT fwd);
    int start;
    int span;
    int p;
    fwd = '0;
    nxt = -1; // Idle.
    if (st >= 0 && eff[st] && !tUp[st])
    begin
      fwd[st] = 1'b1;
      nxt = st;
    end
    else
    begin
      start = (st < 0) ? 0 : st + 1;
      span = (st < 0) ? 5 : 4; // A finished holder skips itself.
      for (int i = 0; i < span; i++)
      begin
        p = (start + i) % 5;
        if (eff[p] && nxt < 0)
          nxt = p;
      end
    end
  endfunction

  always @(negedge clk)
  begin
    portMaskT tUp;
    portMaskT fwd;
    int nxt;
    if (synced)
    begin
      if (outValid !== expValid)
      begin
        $display("FAILED %s: outValid expected %0b actual %0b", testName, expValid, outValid);
        errors++;
      end
      else if (expValid && (outPort !== expPort || outFlit !== expFlit))
      begin
        $display("FAILED %s: port/flit expected %0d/%h actual %0d/%h",
                 testName, expPort, expFlit, outPort, outFlit);
        errors++;
      end
      if (outValid && maskOn && (outPort == 3'd1 || outPort == 3'd2))
      begin
        $display("FAILED %s: port expected 0, 3 or 4 actual %0d", testName, outPort);
        errors++;
      end
      runLen = (outValid && lastValid && outPort == lastPort) ? runLen + 1 : 1;
      if (outValid && capOn && runLen == 3)
      begin
        $display("FAILED %s: burst expected at most 2 actual 3", testName);
        errors++;
      end
      lastValid = outValid;
      lastPort = outPort;
    end
    if (rst)
    begin
      synced = 1'b1;
      mState = -1;
      mMask = '1;
      mCap = '1;
      expValid = 1'b0;
      for (int k = 0; k < 5; k++)
      begin
        mCount[k] = '0;
        mLimit[k] = '0;
      end
    end
    else
    begin
      for (int k = 0; k < 5; k++)
        tUp[k] = (mCount[k] == mLimit[k]);
      nextGrant(mState, reqVec & mMask, tUp, nxt, fwd);
      expValid = |fwd;
      for (int k = 0; k < 5; k++)
      begin
        if (fwd[k])
        begin
          expFlit = flits[k];
          expPort = portIdxT'(k);
        end
        if (ids[k] == flitIdT'(`ROUTER_HEAD_ID))
          mLimit[k] = (lens[k] < mCap) ? lens[k] : mCap;
        mCount[k] = fwd[k] ? mCount[k] + lengthT'(1) : '0;
      end
      mState = nxt;
      if (cfgWrite && !cfgAddr)
        mMask = cfgWdata[4:0];
      if (cfgWrite && cfgAddr)
        mCap = cfgWdata;
    end
  end

  // Request held for cycles clocks, header on the first one.
  task automatic packet(input int k, input int gap, input int len, input int cycles);
    int seq;
    seq = 0;
    repeat (gap) @(posedge clk);
    @(posedge clk);
    #1;
    reqVec[k] = 1'b1;
    ids[k] = flitIdT'(`ROUTER_HEAD_ID);
    lens[k] = lengthT'(len);
    flits[k] = {8'(k), 24'(seq)};
    repeat (cycles - 1)
    begin
      @(posedge clk);
      #1;
      seq++;
      ids[k] = flitIdT'(2); // Payload flit.
      flits[k] = {8'(k), 24'(seq)};
    end
    @(posedge clk);
    #1;
    reqVec[k] = 1'b0;
    ids[k] = '0;
  endtask

  task automatic randomRound();
    int gap [5];
    int len [5];
    int cyc [5];
    for (int k = 0; k < 5; k++)
    begin
      gap[k] = int'($urandom % 4);
      len[k] = 1 + int'($urandom % 6);
      cyc[k] = 1 + int'($urandom % 10);
    end
    fork
      packet(0, gap[0], len[0], cyc[0]);
      packet(1, gap[1], len[1], cyc[1]);
      packet(2, gap[2], len[2], cyc[2]);
      packet(3, gap[3], len[3], cyc[3]);
      packet(4, gap[4], len[4], cyc[4]);
    join
  endtask

  task automatic writeCfg(input logic addr, input lengthT data);
    @(posedge clk);
    #1;
    cfgWrite = 1'b1;
    cfgAddr = addr;
    cfgWdata = data;
    @(posedge clk);
    #1;
    cfgWrite = 1'b0;
  endtask

  task automatic readCfg(input logic addr, input lengthT exp);
    @(posedge clk);
    #1;
    cfgAddr = addr;
    @(negedge clk);
    if (cfgRdata !== exp)
    begin
      $display("FAILED %s: cfgRdata expected %h actual %h", testName, exp, cfgRdata);
      errors++;
    end
  endtask

  // Output must stay low for three cycles in a row.
  task automatic waitQuiet();
    int quiet;
    int n;
    quiet = 0;
    n = 0;
    while (quiet < 3 && n < 100)
    begin
      @(negedge clk);
      quiet = (outValid === 1'b0) ? quiet + 1 : 0;
      n++;
    end
    if (quiet < 3)
    begin
      $display("Output never went idle during %s", testName);
      errors++;
    end
  endtask

  initial
  begin
    #300000;
    $display("Timeout, the run did not reach its end");
    $display("sim failed");
    $finish;
  end

  initial
  begin
    void'($urandom(41));
    rst = 1'b1;
    reqVec = '0;
    cfgWrite = 1'b0;
    cfgAddr = 1'b0;
    cfgWdata = '0;
    for (int k = 0; k < 5; k++)
    begin
      flits[k] = '0;
      ids[k] = '0;
      lens[k] = '0;
    end
    repeat (3) @(posedge clk);
    #1;
    rst = 1'b0;
    repeat (4) @(posedge clk);
    readCfg(1'b0, 12'h01f);
    readCfg(1'b1, 12'hfff);
    testName = "single";
    packet(0, 0, 3, 10);
    waitQuiet();
    testName = "rotate";
    fork
      packet(0, 0, 2, 30);
      packet(1, 0, 3, 30);
      packet(2, 0, 1, 30);
      packet(3, 0, 4, 30);
      packet(4, 0, 2, 30);
    join
    waitQuiet();
    testName = "early";
    fork
      packet(0, 0, 6, 3);
      packet(1, 1, 4, 8);
      packet(3, 0, 5, 2);
    join
    waitQuiet();
    testName = "mask";
    writeCfg(1'b0, 12'h019); // North and East off.
    readCfg(1'b0, 12'h019);
    maskOn = 1'b1;
    repeat (6) randomRound();
    waitQuiet();
    maskOn = 1'b0;
    writeCfg(1'b0, 12'h01f);
    testName = "cap";
    writeCfg(1'b1, 12'd2);
    readCfg(1'b1, 12'd2);
    capOn = 1'b1;
    repeat (6) randomRound();
    waitQuiet();
    capOn = 1'b0;
    $display("Errors: %0d", errors);
    if (errors == 0)
      $display("sim passed");
    else
      $display("sim failed");
    $finish;
  end

endmodule

`default_nettype wire

/* project.f */
+incdir+include
src/routerPkg.sv
src/holdTimer.sv
src/portArbiter.sv
src/portConfig.sv
src/flitCrossbar.sv
src/routerSwitch.sv
dv/tbRouterSwitch.sv

/* Makefile */
TOP = tbRouterSwitch
LOG = sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f project.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "^sim passed$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
